// ==== bench/axi_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model
	import icache_pkg::*;
#(
	parameter int SEED = 32'h1366
)
(
	input  wire logic  clk,
	input  wire logic  req,
	output logic       grnt,
	input  wire addr_t araddr,
	input  wire logic  arvalid,
	output logic       arready,
	output word_t      rdata,
	output logic       rvalid,
	input  wire logic  rready,
	output int         errors
);

	localparam int LINE_WORDS = 2 ** OFFSET_WIDTH;

	int    seed;
	addr_t line_addr;

	function automatic int rand_below(input int span);
		return int'($unsigned($random(seed)) % span);
	endfunction

	// one full line burst, all outputs move on the falling edge
	task automatic serve_line();
		int i;
		// arbiter latency
		repeat (1 + rand_below(4))
			@(negedge clk);
		grnt = 1'b1;
		while (!arvalid)
			@(negedge clk);
		line_addr = araddr;
		assert (line_addr[OFFSET_WIDTH+1:0] == '0)
		else
		begin
			errors++;
			$display("ERR %0t: araddr %h is not line aligned", $time, line_addr);
		end
		// address stall, arvalid and araddr must hold
		repeat (rand_below(4))
		begin
			@(negedge clk);
			assert (arvalid && (araddr == line_addr))
			else
			begin
				errors++;
				$display("ERR %0t: address channel moved while arready low", $time);
			end
		end
		arready = 1'b1;
		@(negedge clk);
		arready = 1'b0;
		// incrementing burst, random gaps between beats
		for (i = 0; i < LINE_WORDS; i++)
		begin
			repeat (rand_below(3))
				@(negedge clk);
			assert (rready)
			else
			begin
				errors++;
				$display("ERR %0t: rready low during the data phase", $time);
			end
			rvalid = 1'b1;
			rdata = (line_addr + 32'(4 * i)) ^ 32'hC0DE_0000;
			@(negedge clk);
			rvalid = 1'b0;
		end
		grnt = 1'b0;
	endtask

	initial
	begin
		seed = SEED;
		errors = 0;
		grnt = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rvalid = 1'b0;
		forever
		begin
			@(negedge clk);
			if (req === 1'b1)
				serve_line();
		end
	end

endmodule

`default_nettype wire

// ==== bench/icache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_tb
	import icache_pkg::*;
();

	localparam int CLK_HALF = 50;
	localparam int CLK_PERIOD = 2 * CLK_HALF;
	localparam int RESET_CYCLES = 16;
	// outputs read a quarter period after the falling edge
	localparam int SAMPLE_DELAY = 25;
	localparam int N_RANDOM = 40;
	// one line of 16 words and 10 accesses on one set
	localparam int N_DIRECTED = 26;
	localparam int N_ACCESS = N_DIRECTED + N_RANDOM;
	localparam int CYCLES_PER_ACCESS = 60;
	localparam int WATCHDOG_NS = (N_ACCESS * CYCLES_PER_ACCESS + RESET_CYCLES) * CLK_PERIOD;

	// three tags in set 1
	localparam addr_t LINE_A = 32'h0000_1040;
	localparam addr_t LINE_B = 32'h0000_2040;
	localparam addr_t LINE_C = 32'h0000_3040;
	// 4 KB window with four tags per set
	localparam addr_t RAND_BASE = 32'h0000_8000;

	logic  clk = 1'b0;
	logic  rst_n;
	logic  cpu_re;
	addr_t cpu_addr;
	word_t cpu_rdata;
	logic  cpu_stall;
	logic  req;
	logic  grnt;
	addr_t araddr;
	logic  arvalid;
	logic  arready;
	word_t rdata;
	logic  rvalid;
	logic  rready;
	int    bus_errs;
	int    data_errs;
	int    ctrl_errs;
	int    seed;
	logic  checking;

	always #CLK_HALF clk = ~clk;

	icache_top #(
		.INDEX_WIDTH (4)
	) uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_re    (cpu_re),
		.cpu_addr  (cpu_addr),
		.cpu_rdata (cpu_rdata),
		.cpu_stall (cpu_stall),
		.req       (req),
		.grnt      (grnt),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rvalid    (rvalid),
		.rready    (rready)
	);

	axi_mem_model #(
		.SEED (32'h1366)
	) u_mem (
		.clk     (clk),
		.req     (req),
		.grnt    (grnt),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rvalid  (rvalid),
		.rready  (rready),
		.errors  (bus_errs)
	);

	// memory contents seen from the cpu
	function automatic word_t expected_word(input addr_t a);
		return a ^ 32'hC0DE_0000;
	endfunction

	task automatic expect_ctrl(input logic cond, input string what);
		assert (cond)
		else
		begin
			ctrl_errs++;
			$display("ERR %0t: %s", $time, what);
		end
	endtask

	// one cpu read that reports whether it stalled and went to the bus
	task automatic fetch(input addr_t a, output logic stalled, output logic req_seen);
		word_t got;
		stalled = 1'b0;
		req_seen = 1'b0;
		@(negedge clk);
		cpu_re = 1'b1;
		cpu_addr = a;
		#SAMPLE_DELAY;
		// address held through the refill
		while (cpu_stall)
		begin
			stalled = 1'b1;
			if (req)
				req_seen = 1'b1;
			@(negedge clk);
			#SAMPLE_DELAY;
		end
		// lookup taken at the coming edge and the word shows up one cycle later
		@(negedge clk);
		cpu_re = 1'b0;
		#SAMPLE_DELAY;
		got = cpu_rdata;
		assert (got == expected_word(a))
		else
		begin
			data_errs++;
			$display("ERR %0t: addr %h read %h, expected %h", $time, a, got, expected_word(a));
		end
	endtask

	// bus only busy while the cpu is held
	initial
	begin
		forever
		begin
			@(negedge clk);
			#SAMPLE_DELAY;
			if (checking)
				expect_ctrl(!(req && !cpu_stall), "req high while cpu_stall low");
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		logic  stalled;
		logic  req_seen;
		int    i;
		addr_t a;
		seed = 32'h1366;
		data_errs = 0;
		ctrl_errs = 0;
		checking = 1'b0;
		rst_n = 1'b0;
		cpu_re = 1'b0;
		cpu_addr = '0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#SAMPLE_DELAY;
		// quiet bus after reset
		expect_ctrl(!req && !arvalid && !rready, "bus controls not low after reset");
		expect_ctrl(!cpu_stall, "cpu_stall high with no read pending");
		checking = 1'b1;

		// cold miss in the middle of a line
		fetch(LINE_A + 32'h8, stalled, req_seen);
		expect_ctrl(stalled && req_seen, "first access to a line did not miss");

		// rest of the line came with the burst
		for (i = 0; i < 16; i++)
		begin
			a = LINE_A + 32'(4 * i);
			if (a != LINE_A + 32'h8)
			begin
				fetch(a, stalled, req_seen);
				expect_ctrl(!stalled && !req_seen, "word of a filled line missed");
			end
		end

		// second tag goes to the other way
		fetch(LINE_B, stalled, req_seen);
		expect_ctrl(req_seen, "second tag in the set did not miss");
		for (i = 0; i < 3; i++)
		begin
			fetch(LINE_B + 32'h3C, stalled, req_seen);
			expect_ctrl(!req_seen, "second tag lost while alternating");
			fetch(LINE_A + 32'h4, stalled, req_seen);
			expect_ctrl(!req_seen, "first tag lost while alternating");
		end
		// LINE_B is now the older one although LINE_A was filled first
		fetch(LINE_C, stalled, req_seen);
		expect_ctrl(req_seen, "third tag in the set did not miss");
		fetch(LINE_A + 32'h10, stalled, req_seen);
		expect_ctrl(!req_seen, "recently used line was evicted");
		fetch(LINE_B, stalled, req_seen);
		expect_ctrl(req_seen, "evicted line still hit");

		// random reads with data checked inside fetch
		for (i = 0; i < N_RANDOM; i++)
		begin
			a = RAND_BASE + (addr_t'($random(seed)) & 32'h0000_0FFC);
			fetch(a, stalled, req_seen);
		end

		checking = 1'b0;
		@(negedge clk);
		$display("errors: data %0d, control %0d, bus %0d", data_errs, ctrl_errs, bus_errs);
		if (data_errs + ctrl_errs + bus_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
	import icache_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       cpu_re,
	input  wire logic       hit,
	input  wire logic       grnt,
	input  wire logic       arready,
	input  wire logic       rvalid,
	input  wire refill_wr_t fill,
	output logic            cpu_stall,
	output logic            req,
	output logic            arvalid,
	output logic            rready,
	output logic            refill_start,
	output logic            addr_phase,
	output logic            data_phase,
	output logic            lookup_done
);

	ctrl_state_t state;
	logic        idle;

	assign idle = (state == IDLE);

	// only idle can accept a lookup
	assign cpu_stall = !(idle && (!cpu_re || hit));
	assign lookup_done = idle && cpu_re && hit;
	// miss seen in idle, refill unit latches the line address
	assign refill_start = idle && cpu_re && !hit;

	assign addr_phase = (state == ADDR_SEND);
	assign data_phase = (state == DATA_RECV);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			req <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// req stays up for the whole refill
					if (refill_start)
					begin
						state <= BUS_WAIT;
						req <= 1'b1;
					end
				end
				BUS_WAIT:
				begin
					if (grnt)
					begin
						state <= ADDR_SEND;
						arvalid <= 1'b1;
					end
				end
				ADDR_SEND:
				begin
					// arvalid held until the slave takes the address
					if (arready)
					begin
						state <= DATA_RECV;
						arvalid <= 1'b0;
						rready <= 1'b1;
					end
				end
				DATA_RECV:
				begin
					// beat counter in the refill unit flags the end
					if (rvalid && fill.last)
					begin
						state <= DELAY;
						rready <= 1'b0;
						req <= 1'b0;
					end
				end
				DELAY:
				begin
					// tag write settles, lookup retried in idle
					state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/icache_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_data_store
	import icache_pkg::*;
#(
	parameter int INDEX_WIDTH = 4
)
(
	input  wire logic       clk,
	input  wire logic       lookup_done,
	input  wire logic       hit_way,
	input  wire addr_t      cpu_addr,
	input  wire refill_wr_t fill,
	output word_t           cpu_rdata
);

	localparam int DEPTH = 2 ** (INDEX_WIDTH + OFFSET_WIDTH);

	typedef logic [INDEX_WIDTH-1:0] index_t;

	index_t  index;
	offset_t rd_offset;
	word_t   rd_word [2];
	logic    way_q;

	assign index = cpu_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
	assign rd_offset = cpu_addr[2 +: OFFSET_WIDTH];

	// one single port ram per way
	for (genvar w = 0; w < 2; w++)
	begin : g_way
		word_t mem [DEPTH];

		always_ff @(posedge clk)
		begin
			// refill owns the port during the burst
			if (fill.we && (fill.way == 1'(w)))
				mem[{index, fill.offset}] <= fill.data;
			else if (lookup_done)
				rd_word[w] <= mem[{index, rd_offset}];
		end
	end

	// hit way follows the read by one cycle
	always_ff @(posedge clk)
	begin
		if (lookup_done)
			way_q <= hit_way;
	end

	assign cpu_rdata = way_q ? rd_word[1] : rd_word[0];

endmodule

`default_nettype wire

// ==== hw/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// byte address and instruction word
	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 32;
	// word offset in a line, 16 words per line
	localparam int OFFSET_WIDTH = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [OFFSET_WIDTH-1:0] offset_t;

	// lookup, bus request, address, burst data, settle
	typedef enum logic [2:0] {
		IDLE,
		BUS_WAIT,
		ADDR_SEND,
		DATA_RECV,
		DELAY
	} ctrl_state_t;

	// one refill beat into the stores
	typedef struct packed {
		logic    we;
		logic    way;
		offset_t offset;
		word_t   data;
		// beat that completes the line
		logic    last;
	} refill_wr_t;

endpackage

`default_nettype wire

// ==== hw/icache_refill.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_refill
	import icache_pkg::*;
#(
	parameter int INDEX_WIDTH = 4
)
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  refill_start,
	input  wire logic  addr_phase,
	input  wire logic  data_phase,
	input  wire logic  rvalid,
	input  wire logic  victim_way,
	input  wire addr_t cpu_addr,
	input  wire word_t rdata,
	output addr_t      araddr,
	output refill_wr_t fill
);

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;

	tag_t    tag_q;
	index_t  index_q;
	logic    way_q;
	offset_t beat;
	logic    beat_ok;

	// miss line and victim held for the whole burst
	always_ff @(posedge clk)
	begin
		if (refill_start)
		begin
			tag_q <= cpu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
			index_q <= cpu_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
			way_q <= victim_way;
		end
	end

	// rready is up all through the data phase
	assign beat_ok = data_phase && rvalid;

	// counter restarts with every miss, stalls while rvalid is low
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			beat <= '0;
		else if (refill_start)
			beat <= '0;
		else if (beat_ok)
			beat <= beat + 1'b1;
	end

	// line aligned, burst starts at word 0
	assign araddr = addr_phase ? {tag_q, index_q, {(OFFSET_WIDTH + 2){1'b0}}} : '0;

	always_comb
	begin
		fill.we = beat_ok;
		fill.way = way_q;
		fill.offset = beat;
		fill.data = rdata;
		fill.last = (beat == '1);
	end

endmodule

`default_nettype wire

// ==== hw/icache_tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_tag_store
	import icache_pkg::*;
#(
	parameter int INDEX_WIDTH = 4
)
(
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       lookup_done,
	input  wire addr_t      cpu_addr,
	input  wire refill_wr_t fill,
	output logic            hit,
	output logic            hit_way,
	output logic            victim_way
);

	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
	localparam int SETS = 2 ** INDEX_WIDTH;

	typedef logic [TAG_WIDTH-1:0] tag_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;

	tag_t            tag_mem [2][SETS];
	logic [SETS-1:0] valid [2];
	// per set, points at the less recently used way
	logic [SETS-1:0] lru;
	tag_t            addr_tag;
	index_t          index;
	logic [1:0]      way_hit;
	logic            fill_done;

	// tag | index | word offset | byte offset
	assign addr_tag = cpu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign index = cpu_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];

	// both ways compared in parallel
	for (genvar w = 0; w < 2; w++)
	begin : g_cmp
		assign way_hit[w] = valid[w][index] && (tag_mem[w][index] == addr_tag);
	end

	assign hit = |way_hit;
	// way 1 wins the encode, never both after a clean refill
	assign hit_way = way_hit[1];
	assign victim_way = lru[index];

	assign fill_done = fill.we && fill.last;

	// tag written together with the last beat
	always_ff @(posedge clk)
	begin
		if (fill_done)
			tag_mem[fill.way][index] <= addr_tag;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid[0] <= '0;
			valid[1] <= '0;
			lru <= '0;
		end
		else if (fill_done)
		begin
			valid[fill.way][index] <= 1'b1;
			// freshly filled way becomes the recent one
			lru[index] <= ~fill.way;
		end
		else if (lookup_done)
		begin
			lru[index] <= ~hit_way;
		end
	end

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_top
	import icache_pkg::*;
#(
	parameter int INDEX_WIDTH = 4
)
(
	input  wire logic  clk,
	input  wire logic  rst_n,
	// cpu side
	input  wire logic  cpu_re,
	input  wire addr_t cpu_addr,
	output word_t      cpu_rdata,
	output logic       cpu_stall,
	// bus arbiter
	output logic       req,
	input  wire logic  grnt,
	// read address channel
	output addr_t      araddr,
	output logic       arvalid,
	input  wire logic  arready,
	// read data channel
	input  wire word_t rdata,
	input  wire logic  rvalid,
	output logic       rready
);

	logic       hit;
	logic       hit_way;
	logic       victim_way;
	logic       refill_start;
	logic       addr_phase;
	logic       data_phase;
	logic       lookup_done;
	refill_wr_t fill;

	icache_ctrl u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_re       (cpu_re),
		.hit          (hit),
		.grnt         (grnt),
		.arready      (arready),
		.rvalid       (rvalid),
		.fill         (fill),
		.cpu_stall    (cpu_stall),
		.req          (req),
		.arvalid      (arvalid),
		.rready       (rready),
		.refill_start (refill_start),
		.addr_phase   (addr_phase),
		.data_phase   (data_phase),
		.lookup_done  (lookup_done)
	);

	icache_tag_store #(
		.INDEX_WIDTH (INDEX_WIDTH)
	) u_tag_store (
		.clk         (clk),
		.rst_n       (rst_n),
		.lookup_done (lookup_done),
		.cpu_addr    (cpu_addr),
		.fill        (fill),
		.hit         (hit),
		.hit_way     (hit_way),
		.victim_way  (victim_way)
	);

	icache_data_store #(
		.INDEX_WIDTH (INDEX_WIDTH)
	) u_data_store (
		.clk         (clk),
		.lookup_done (lookup_done),
		.hit_way     (hit_way),
		.cpu_addr    (cpu_addr),
		.fill        (fill),
		.cpu_rdata   (cpu_rdata)
	);

	icache_refill #(
		.INDEX_WIDTH (INDEX_WIDTH)
	) u_refill (
		.clk          (clk),
		.rst_n        (rst_n),
		.refill_start (refill_start),
		.addr_phase   (addr_phase),
		.data_phase   (data_phase),
		.rvalid       (rvalid),
		.victim_way   (victim_way),
		.cpu_addr     (cpu_addr),
		.rdata        (rdata),
		.araddr       (araddr),
		.fill         (fill)
	);

endmodule

`default_nettype wire

// ==== icache.f ====
hw/icache_pkg.sv
hw/icache_ctrl.sv
hw/icache_tag_store.sv
hw/icache_data_store.sv
hw/icache_refill.sv
hw/icache_top.sv
bench/axi_mem_model.sv
bench/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f icache.f --top-module icache_tb -o icache_sim \
	&& ./obj_dir/icache_sim > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }
cat sim.log
grep -Fqx '** PASS **' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
